/* hdl/lcd_pkg.sv */
package lcd_pkg;

	typedef logic [15:0] word_t;
	typedef logic [3:0]  apb_addr_t;
	typedef logic [31:0] apb_data_t;
	typedef logic [7:0]  ms_t;
	typedef logic [16:0] count_t;

	typedef enum logic [1:0] {
		op_cmd,
		op_data,
		op_delay,
		op_end
	} rom_op_e;

	// Bus word for cmd/data entries, delay length for delay entries
	typedef union packed {
		word_t word;
		struct packed {
			logic [7:0] pad;
			ms_t        ms;
		} dly;
	} rom_arg_u;

	typedef struct packed {
		rom_op_e  op;
		rom_arg_u arg;
	} rom_entry_t;

	// Init sequence holds 44 entries
	localparam int rom_depth = 64;
	typedef logic [$clog2(rom_depth)-1:0] rom_addr_t;

	localparam apb_addr_t reg_ctrl   = 4'h0;
	localparam apb_addr_t reg_color  = 4'h4;
	localparam apb_addr_t reg_count  = 4'h8;
	localparam apb_addr_t reg_status = 4'hc;

	localparam logic [7:0] cmd_data_rw    = 8'h22; // Memory write
	localparam logic [7:0] cmd_test_mode  = 8'h83;
	localparam logic [7:0] cmd_vddd       = 8'h85;
	localparam logic [7:0] cmd_vgs_res1   = 8'h8b;
	localparam logic [7:0] cmd_vgs_res2   = 8'h8c;
	localparam logic [7:0] cmd_pwm0       = 8'h91;
	localparam logic [7:0] cmd_osc1       = 8'h17;
	localparam logic [7:0] cmd_cycle1     = 8'h2b;
	localparam logic [7:0] cmd_pwr1       = 8'h19;
	localparam logic [7:0] cmd_pwr2       = 8'h1a;
	localparam logic [7:0] cmd_pwr3       = 8'h1b;
	localparam logic [7:0] cmd_pwr4       = 8'h1c;
	localparam logic [7:0] cmd_pwr6       = 8'h1e;
	localparam logic [7:0] cmd_vcom       = 8'h1f;
	localparam logic [7:0] cmd_disp2      = 8'h24;
	localparam logic [7:0] cmd_mem_access = 8'h16;
	localparam logic [7:0] cmd_disp_mode  = 8'h01;

	localparam ms_t panel_rst_ms = 8'd1; // Reset low time and settle time

endpackage

/* hdl/lcd_ifs.sv */
`timescale 1ns/1ps

interface lcd_word_if;
	import lcd_pkg::*;

	logic  valid;
	logic  ready;
	logic  is_data; // Drives RS
	word_t word;

	modport src (output valid, output is_data, output word, input ready);
	modport sink (input valid, input is_data, input word, output ready);
endinterface

interface lcd_cmd_if;
	import lcd_pkg::*;

	logic   start_init; // Single-cycle pulses
	logic   start_fill;
	word_t  color;
	count_t fill_count;
	logic   init_done;
	logic   busy;

	modport regs (
		output start_init, start_fill, color, fill_count,
		input  init_done, busy
	);
	modport seq (
		input  start_init, start_fill, color, fill_count,
		output init_done, busy
	);
endinterface

/* hdl/lcd_apb_regs.sv */
`timescale 1ns/1ps

module lcd_apb_regs (
	input  logic               clk,
	input  logic               rst,
	input  logic               psel,
	input  logic               penable,
	input  logic               pwrite,
	input  lcd_pkg::apb_addr_t paddr,
	input  lcd_pkg::apb_data_t pwdata,
	output lcd_pkg::apb_data_t prdata,
	output logic               pready,
	output logic               pslverr,
	lcd_cmd_if.regs            cmd
);
	import lcd_pkg::*;

	logic   access;
	logic   wr_ok;
	logic   mapped;
	logic   cmd_bad;
	logic   err;
	word_t  color_q;
	count_t count_q;
	logic   start_init_q;
	logic   start_fill_q;

	assign access = psel & penable;
	assign mapped = paddr inside {reg_ctrl, reg_color, reg_count, reg_status};

	// Start while busy, or fill before init
	assign cmd_bad = pwrite && (paddr == reg_ctrl) &&
		((|pwdata[1:0] && cmd.busy) || (pwdata[1] && !cmd.init_done));

	assign err     = !mapped || (pwrite && paddr == reg_status) || cmd_bad;
	assign wr_ok   = access & pwrite & ~err;
	assign pready  = 1'b1; // No wait states
	assign pslverr = access & err;

	always_comb begin
		case (paddr)
			reg_color:  prdata = apb_data_t'(color_q);
			reg_count:  prdata = apb_data_t'(count_q);
			reg_status: prdata = apb_data_t'({cmd.busy, cmd.init_done});
			default:    prdata = '0; // CTRL reads as zero
		endcase
	end

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			color_q      <= '0;
			count_q      <= '0;
			start_init_q <= 1'b0;
			start_fill_q <= 1'b0;
		end else begin
			start_init_q <= wr_ok && (paddr == reg_ctrl) && pwdata[0];
			start_fill_q <= wr_ok && (paddr == reg_ctrl) && pwdata[1];
			if (wr_ok && paddr == reg_color)
				color_q <= pwdata[15:0];
			if (wr_ok && paddr == reg_count)
				count_q <= pwdata[16:0];
		end
	end

	assign cmd.start_init = start_init_q;
	assign cmd.start_fill = start_fill_q;
	assign cmd.color      = color_q;
	assign cmd.fill_count = count_q;

endmodule

/* hdl/lcd_delay_timer.sv */
`timescale 1ns/1ps

module lcd_delay_timer #(
	parameter int clks_per_ms = 50000
) (
	input  logic         clk,
	input  logic         rst,
	input  logic         start,
	input  lcd_pkg::ms_t ms,
	output logic         expired
);
	import lcd_pkg::*;

	localparam int pre_w = (clks_per_ms > 2) ? $clog2(clks_per_ms) : 1;
	localparam logic [pre_w-1:0] pre_top   = pre_w'(clks_per_ms - 1);
	localparam logic [pre_w-1:0] pre_first = pre_w'(clks_per_ms - 2); // Start cycle counts

	logic [pre_w-1:0] pre_cnt;
	ms_t              ms_cnt;

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			pre_cnt <= '0;
			ms_cnt  <= '0;
		end else if (start) begin
			pre_cnt <= pre_first;
			ms_cnt  <= ms;
		end else if (ms_cnt != '0) begin
			if (pre_cnt == '0) begin
				pre_cnt <= pre_top; // One ms tick
				ms_cnt  <= ms_cnt - 1'b1;
			end else begin
				pre_cnt <= pre_cnt - 1'b1;
			end
		end
	end

	assign expired = (ms_cnt == '0);

endmodule

/* hdl/lcd_init_rom.sv */
`timescale 1ns/1ps

module lcd_init_rom (
	input  lcd_pkg::rom_addr_t  addr,
	output lcd_pkg::rom_entry_t entry
);
	import lcd_pkg::*;

	function automatic rom_entry_t w_cmd(input logic [7:0] code);
		rom_entry_t e;
		e.op       = op_cmd;
		e.arg.word = {8'h00, code};
		return e;
	endfunction

	function automatic rom_entry_t w_data(input logic [7:0] value);
		rom_entry_t e;
		e.op       = op_data;
		e.arg.word = {8'h00, value};
		return e;
	endfunction

	function automatic rom_entry_t w_delay(input ms_t len);
		rom_entry_t e;
		e.op           = op_delay;
		e.arg.dly.pad  = '0;
		e.arg.dly.ms   = len;
		return e;
	endfunction

	always_comb begin
		case (addr)
			0:  entry = w_cmd(cmd_test_mode);
			1:  entry = w_data(8'h02); // Test mode on
			2:  entry = w_cmd(cmd_vddd);
			3:  entry = w_data(8'h03);
			4:  entry = w_cmd(cmd_vgs_res1);
			5:  entry = w_data(8'h01);
			6:  entry = w_cmd(cmd_vgs_res2);
			7:  entry = w_data(8'h93);
			8:  entry = w_cmd(cmd_pwm0);
			9:  entry = w_data(8'h01);
			10: entry = w_cmd(cmd_test_mode);
			11: entry = w_data(8'h00); // Test mode off
			12: entry = w_cmd(cmd_osc1);
			13: entry = w_data(8'h91);
			14: entry = w_cmd(cmd_cycle1);
			15: entry = w_data(8'hf9);
			16: entry = w_delay(8'd10);
			17: entry = w_cmd(cmd_pwr3);
			18: entry = w_data(8'h14);
			19: entry = w_cmd(cmd_pwr2);
			20: entry = w_data(8'h11);
			21: entry = w_cmd(cmd_pwr4);
			22: entry = w_data(8'h06);
			23: entry = w_cmd(cmd_vcom);
			24: entry = w_data(8'h42);
			25: entry = w_delay(8'd20);
			26: entry = w_cmd(cmd_pwr1);
			27: entry = w_data(8'h0a);
			28: entry = w_cmd(cmd_pwr1);
			29: entry = w_data(8'h1a);
			30: entry = w_delay(8'd40);
			31: entry = w_cmd(cmd_pwr1);
			32: entry = w_data(8'h12);
			33: entry = w_delay(8'd40);
			34: entry = w_cmd(cmd_pwr6);
			35: entry = w_data(8'h27);
			36: entry = w_delay(8'd100);
			37: entry = w_cmd(cmd_disp2); // Display on
			38: entry = w_data(8'h38);
			39: entry = w_cmd(cmd_mem_access);
			40: entry = w_data(8'h1c);
			41: entry = w_cmd(cmd_disp_mode);
			42: entry = w_data(8'h06);
			default: entry = '{op: op_end, arg: '0};
		endcase
	end

endmodule

/* hdl/lcd_bus_writer.sv */
`timescale 1ns/1ps

module lcd_bus_writer (
	input  logic           clk,
	input  logic           rst,
	lcd_word_if.sink       bus,
	output lcd_pkg::word_t lcd_data,
	output logic           lcd_rs,
	output logic           lcd_wr,
	output logic           lcd_cs
);
	typedef enum logic [1:0] {
		w_idle,
		w_strobe,
		w_hold
	} wr_state_e;

	wr_state_e state;
	logic      accept;

	assign bus.ready = (state == w_idle); // One word in flight
	assign accept    = bus.valid & bus.ready;

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			state  <= w_idle;
			lcd_cs <= 1'b1;
			lcd_wr <= 1'b1;
			lcd_rs <= 1'b1;
		end else begin
			case (state)
				w_idle: begin
					if (accept) begin
						lcd_cs <= 1'b0;
						lcd_wr <= 1'b0;
						lcd_rs <= bus.is_data;
						state  <= w_strobe;
					end
				end
				w_strobe: begin
					lcd_wr <= 1'b1; // Panel latches on this edge
					state  <= w_hold;
				end
				w_hold: begin
					lcd_cs <= 1'b1;
					state  <= w_idle;
				end
				default: state <= w_idle;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (accept)
			lcd_data <= bus.word;
	end

endmodule

/* hdl/lcd_sequencer.sv */
`timescale 1ns/1ps

module lcd_sequencer (
	input  logic                clk,
	input  logic                rst,
	lcd_cmd_if.seq              cmd,
	lcd_word_if.src             bus,
	output lcd_pkg::rom_addr_t  rom_addr,
	input  lcd_pkg::rom_entry_t rom_entry,
	output logic                tmr_start,
	output lcd_pkg::ms_t        tmr_ms,
	input  logic                tmr_expired,
	output logic                lcd_rst
);
	import lcd_pkg::*;

	typedef enum logic [2:0] {
		s_idle,
		s_rst_low,
		s_rst_wait,
		s_rom_issue,
		s_rom_send,
		s_rom_wait,
		s_fill,
		s_drain
	} state_e;

	state_e state;
	logic   valid_q;
	logic   is_data_q;
	word_t  word_q;
	count_t remaining;
	logic   init_done_q;
	logic   xfer;
	logic   tmr_done;
	logic   last_word;

	assign xfer     = bus.valid & bus.ready;
	assign tmr_done = tmr_expired & ~tmr_start; // Expired is stale in the start cycle

	// Command word with zero count ends the fill at once
	assign last_word = is_data_q ? (remaining == count_t'(1)) : (remaining == '0);

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			state       <= s_idle;
			valid_q     <= 1'b0;
			tmr_start   <= 1'b0;
			lcd_rst     <= 1'b1;
			init_done_q <= 1'b0;
		end else begin
			tmr_start <= 1'b0;
			case (state)
				s_idle: begin
					if (cmd.start_init) begin
						lcd_rst     <= 1'b0;
						init_done_q <= 1'b0;
						tmr_start   <= 1'b1;
						state       <= s_rst_low;
					end else if (cmd.start_fill) begin
						valid_q <= 1'b1;
						state   <= s_fill;
					end
				end
				s_rst_low: begin
					if (tmr_done) begin
						lcd_rst   <= 1'b1;
						tmr_start <= 1'b1;
						state     <= s_rst_wait;
					end
				end
				s_rst_wait: if (tmr_done) state <= s_rom_issue;
				s_rom_issue: begin
					case (rom_entry.op)
						op_cmd, op_data: begin
							valid_q <= 1'b1;
							state   <= s_rom_send;
						end
						op_delay: begin
							tmr_start <= 1'b1;
							state     <= s_rom_wait;
						end
						default: begin
							init_done_q <= 1'b1;
							state       <= s_drain;
						end
					endcase
				end
				s_rom_send: begin
					if (xfer) begin
						valid_q <= 1'b0;
						state   <= s_rom_issue;
					end
				end
				s_rom_wait: if (tmr_done) state <= s_rom_issue;
				s_fill: begin
					if (xfer && last_word) begin
						valid_q <= 1'b0;
						state   <= s_drain;
					end
				end
				s_drain: if (bus.ready) state <= s_idle; // Last write leaves the pins
				default: state <= s_idle;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		case (state)
			s_idle: begin
				is_data_q <= 1'b0;
				word_q    <= {8'h00, cmd_data_rw};
				remaining <= cmd.fill_count;
				tmr_ms    <= panel_rst_ms;
			end
			s_rst_wait: rom_addr <= '0;
			s_rom_issue: begin
				is_data_q <= (rom_entry.op == op_data);
				word_q    <= rom_entry.arg.word;
				tmr_ms    <= rom_entry.arg.dly.ms;
			end
			s_rom_send: if (xfer) rom_addr <= rom_addr + 1'b1;
			s_rom_wait: if (tmr_done) rom_addr <= rom_addr + 1'b1;
			s_fill: begin
				if (xfer) begin
					if (is_data_q) begin
						remaining <= remaining - 1'b1;
					end else begin
						is_data_q <= 1'b1;
						word_q    <= cmd.color; // Held for all pixels
					end
				end
			end
			default: ;
		endcase
	end

	assign bus.valid     = valid_q;
	assign bus.is_data   = is_data_q;
	assign bus.word      = word_q;
	assign cmd.busy      = (state != s_idle);
	assign cmd.init_done = init_done_q;

endmodule

/* hdl/lcd_top.sv */
`timescale 1ns/1ps

module lcd_top #(
	parameter int clks_per_ms = 50000
) (
	input  logic               clk,
	input  logic               rst,
	input  logic               psel,
	input  logic               penable,
	input  logic               pwrite,
	input  lcd_pkg::apb_addr_t paddr,
	input  lcd_pkg::apb_data_t pwdata,
	output lcd_pkg::apb_data_t prdata,
	output logic               pready,
	output logic               pslverr,
	output lcd_pkg::word_t     lcd_data,
	output logic               lcd_rs,
	output logic               lcd_wr,
	output logic               lcd_cs,
	output logic               lcd_rst
);
	import lcd_pkg::*;

	rom_addr_t  rom_addr;
	rom_entry_t rom_entry;
	logic       tmr_start;
	ms_t        tmr_ms;
	logic       tmr_expired;

	lcd_word_if word_bus ();
	lcd_cmd_if  cmd_bus ();

	lcd_apb_regs lcd_apb_regs_i (
		.clk     (clk),
		.rst     (rst),
		.psel    (psel),
		.penable (penable),
		.pwrite  (pwrite),
		.paddr   (paddr),
		.pwdata  (pwdata),
		.prdata  (prdata),
		.pready  (pready),
		.pslverr (pslverr),
		.cmd     (cmd_bus.regs)
	);

	lcd_sequencer lcd_sequencer_i (
		.clk         (clk),
		.rst         (rst),
		.cmd         (cmd_bus.seq),
		.bus         (word_bus.src),
		.rom_addr    (rom_addr),
		.rom_entry   (rom_entry),
		.tmr_start   (tmr_start),
		.tmr_ms      (tmr_ms),
		.tmr_expired (tmr_expired),
		.lcd_rst     (lcd_rst)
	);

	lcd_delay_timer #(
		.clks_per_ms (clks_per_ms)
	) lcd_delay_timer_i (
		.clk     (clk),
		.rst     (rst),
		.start   (tmr_start),
		.ms      (tmr_ms),
		.expired (tmr_expired)
	);

	lcd_init_rom lcd_init_rom_i (
		.addr  (rom_addr),
		.entry (rom_entry)
	);

	lcd_bus_writer lcd_bus_writer_i (
		.clk      (clk),
		.rst      (rst),
		.bus      (word_bus.sink),
		.lcd_data (lcd_data),
		.lcd_rs   (lcd_rs),
		.lcd_wr   (lcd_wr),
		.lcd_cs   (lcd_cs)
	);

endmodule

/* dv/lcd_props.sv */
`timescale 1ns/1ps

module lcd_props (
	input logic           clk,
	input logic           rst,
	input logic           lcd_cs,
	input logic           lcd_wr,
	input logic           valid,
	input logic           ready,
	input logic           is_data,
	input lcd_pkg::word_t word,
	input logic           pready
);

	wr_inside_cs: assert property (@(posedge clk) disable iff (rst) !lcd_wr |-> !lcd_cs)
		else $error("lcd_wr low while lcd_cs is high");

	valid_held: assert property (@(posedge clk) disable iff (rst) valid && !ready |=> valid)
		else $error("valid dropped before ready");

	payload_stable: assert property (@(posedge clk) disable iff (rst)
		valid && !ready |=> $stable(word) && $stable(is_data))
		else $error("word payload changed while stalled");

	no_wait_states: assert property (@(posedge clk) disable iff (rst) pready)
		else $error("pready low");

endmodule

bind lcd_top lcd_props lcd_props_i (
	.clk     (clk),
	.rst     (rst),
	.lcd_cs  (lcd_cs),
	.lcd_wr  (lcd_wr),
	.valid   (word_bus.valid),
	.ready   (word_bus.ready),
	.is_data (word_bus.is_data),
	.word    (word_bus.word),
	.pready  (pready)
);

/* dv/lcd_tb.sv */
`timescale 1ns/1ps

module lcd_tb;
	import lcd_pkg::*;

	localparam int  clks_per_ms     = 8;
	localparam time ms_ns           = clks_per_ms * 40;
	localparam int  watchdog_cycles = (400 + 2 * 41) * clks_per_ms + 4000;

	// Command byte and data byte of each init pair
	localparam logic [15:0] init_pairs [19] = '{
		16'h8302, 16'h8503, 16'h8b01, 16'h8c93, 16'h9101, 16'h8300, 16'h1791,
		16'h2bf9, 16'h1b14, 16'h1a11, 16'h1c06, 16'h1f42, 16'h190a, 16'h191a,
		16'h1912, 16'h1e27, 16'h2438, 16'h161c, 16'h0106
	};

	logic      clk;
	logic      rst;
	logic      psel;
	logic      penable;
	logic      pwrite;
	apb_addr_t paddr;
	apb_data_t pwdata;
	apb_data_t prdata;
	logic      pready;
	logic      pslverr;
	word_t     lcd_data;
	logic      lcd_rs;
	logic      lcd_wr;
	logic      lcd_cs;
	logic      lcd_rst;

	int          errors;
	logic [31:0] rng;
	logic [16:0] wr_q[$]; // {rs, data} per strobe
	time         wr_t[$];
	time         rst_fall_t;
	time         rst_rise_t;

	lcd_top #(
		.clks_per_ms (clks_per_ms)
	) lcd_top_i (
		.clk      (clk),
		.rst      (rst),
		.psel     (psel),
		.penable  (penable),
		.pwrite   (pwrite),
		.paddr    (paddr),
		.pwdata   (pwdata),
		.prdata   (prdata),
		.pready   (pready),
		.pslverr  (pslverr),
		.lcd_data (lcd_data),
		.lcd_rs   (lcd_rs),
		.lcd_wr   (lcd_wr),
		.lcd_cs   (lcd_cs),
		.lcd_rst  (lcd_rst)
	);

	initial clk = 1'b0;
	always #20 clk = ~clk;

	always @(posedge lcd_wr) begin
		if (!rst && lcd_cs === 1'b0) begin // Panel latches here
			wr_q.push_back({lcd_rs, lcd_data});
			wr_t.push_back($time);
		end
	end

	always @(negedge lcd_rst) rst_fall_t = $time;
	always @(posedge lcd_rst) rst_rise_t = $time;

	function automatic logic [31:0] xorshift(input logic [31:0] s);
		logic [31:0] x;
		x = s;
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	function automatic int delay_after(input int pair);
		case (pair)
			7:       return 10;
			11:      return 20;
			13:      return 40;
			14:      return 40;
			15:      return 100;
			default: return 0;
		endcase
	endfunction

	task automatic check_word(input string name, input word_t got, input word_t exp);
		if (got !== exp) begin
			$display("** Error at %0t: %s = %h, expected %h", $time, name, got, exp);
			errors++;
		end
	endtask

	task automatic check_bit(input string name, input logic got, input logic exp);
		if (got !== exp) begin
			$display("** Error at %0t: %s = %b, expected %b", $time, name, got, exp);
			errors++;
		end
	endtask

	task automatic check_data(input string name, input apb_data_t got, input apb_data_t exp);
		if (got !== exp) begin
			$display("** Error at %0t: %s = %h, expected %h", $time, name, got, exp);
			errors++;
		end
	endtask

	task automatic apb_write(input apb_addr_t addr, input apb_data_t data, output logic err);
		@(posedge clk);
		psel    <= 1'b1;
		penable <= 1'b0;
		pwrite  <= 1'b1;
		paddr   <= addr;
		pwdata  <= data;
		@(posedge clk);
		penable <= 1'b1;
		@(negedge clk);
		err = pslverr;
		@(posedge clk);
		psel    <= 1'b0;
		penable <= 1'b0;
	endtask

	task automatic apb_read(input apb_addr_t addr, output apb_data_t data, output logic err);
		@(posedge clk);
		psel    <= 1'b1;
		penable <= 1'b0;
		pwrite  <= 1'b0;
		paddr   <= addr;
		@(posedge clk);
		penable <= 1'b1;
		@(negedge clk);
		data = prdata;
		err  = pslverr;
		@(posedge clk);
		psel    <= 1'b0;
		penable <= 1'b0;
	endtask

	task automatic wait_idle;
		apb_data_t st;
		logic      err;
		int        polls;
		polls = 0;
		do begin
			apb_read(reg_status, st, err);
			polls++;
		end while (st[1] && polls < 1000);
		if (st[1]) begin
			$display("Timeout: busy still set after %0d status reads", polls);
			errors++;
		end
	endtask

	task automatic check_fill(input int n, input word_t color);
		if (wr_q.size() != n + 1) begin
			$display("Fill gave %0d panel writes instead of %0d", wr_q.size(), n + 1);
			errors++;
		end else begin
			check_bit("lcd_rs", wr_q[0][16], 1'b0);
			check_word("lcd_data", wr_q[0][15:0], 16'h0022);
			for (int i = 1; i <= n; i++) begin
				check_bit("lcd_rs", wr_q[i][16], 1'b1);
				check_word("lcd_data", wr_q[i][15:0], color);
			end
		end
	endtask

	task automatic reset_state;
		apb_data_t st;
		logic      err;
		apb_read(reg_status, st, err);
		check_data("status", st, 32'h0);
		@(negedge clk);
		check_bit("lcd_cs", lcd_cs, 1'b1);
		check_bit("lcd_wr", lcd_wr, 1'b1);
		check_bit("lcd_rst", lcd_rst, 1'b1);
		apb_write(reg_ctrl, 32'h2, err); // Fill before init
		check_bit("pslverr", err, 1'b1);
		apb_read(reg_status, st, err);
		check_data("status", st, 32'h0);
	endtask

	task automatic init_sequence;
		apb_data_t st;
		logic      err;
		time       gap;
		wr_q.delete();
		wr_t.delete();
		rst_fall_t = 0;
		rst_rise_t = 0;
		apb_write(reg_ctrl, 32'h1, err);
		check_bit("pslverr", err, 1'b0);
		wait_idle();
		if (!(rst_fall_t > 0 && rst_rise_t > rst_fall_t)) begin
			$display("No reset pulse seen on lcd_rst");
			errors++;
		end else if (rst_rise_t - rst_fall_t < ms_ns) begin
			$display("Reset pulse on lcd_rst shorter than 1 ms");
			errors++;
		end
		if (wr_q.size() != 38) begin
			$display("Init gave %0d panel writes instead of 38", wr_q.size());
			errors++;
		end else begin
			if (wr_t[0] < rst_rise_t + ms_ns) begin
				$display("Write strobe during panel reset or the settle time after it");
				errors++;
			end
			for (int i = 0; i < 19; i++) begin
				check_bit("lcd_rs", wr_q[2 * i][16], 1'b0);
				check_word("lcd_data", wr_q[2 * i][15:0],
					{8'h00, init_pairs[i][15:8]});
				check_bit("lcd_rs", wr_q[2 * i + 1][16], 1'b1);
				check_word("lcd_data", wr_q[2 * i + 1][15:0],
					{8'h00, init_pairs[i][7:0]});
				if (delay_after(i) > 0) begin
					gap = wr_t[2 * i + 2] - wr_t[2 * i + 1];
					if (gap < delay_after(i) * ms_ns) begin
						$display("Delay of %0d ms after pair %0d lasted only %0t",
							delay_after(i), i, gap);
						errors++;
					end
				end
			end
		end
		apb_read(reg_status, st, err);
		check_data("status", st, 32'h1);
	endtask

	task automatic random_fill;
		apb_data_t st;
		logic      err;
		int        cnt;
		word_t     color;
		rng = xorshift(rng);
		cnt = 1 + int'(rng % 32'd40);
		rng = xorshift(rng);
		color = rng[15:0];
		apb_write(reg_color, apb_data_t'(color), err);
		check_bit("pslverr", err, 1'b0);
		apb_write(reg_count, apb_data_t'(cnt), err);
		check_bit("pslverr", err, 1'b0);
		apb_read(reg_color, st, err);
		check_data("color", st, apb_data_t'(color));
		apb_read(reg_count, st, err);
		check_data("count", st, apb_data_t'(cnt));
		wr_q.delete();
		wr_t.delete();
		apb_write(reg_ctrl, 32'h2, err);
		check_bit("pslverr", err, 1'b0);
		wait_idle();
		check_fill(cnt, color);
		apb_read(reg_status, st, err);
		check_data("status", st, 32'h1); // Busy back to zero
	endtask

	task automatic busy_reject;
		apb_data_t st;
		logic      err;
		word_t     color;
		rng = xorshift(rng);
		color = rng[15:0];
		apb_write(reg_color, apb_data_t'(color), err);
		apb_write(reg_count, 32'd40, err);
		wr_q.delete();
		wr_t.delete();
		apb_write(reg_ctrl, 32'h2, err);
		check_bit("pslverr", err, 1'b0);
		apb_write(reg_ctrl, 32'h1, err);
		check_bit("pslverr", err, 1'b1);
		apb_write(reg_ctrl, 32'h2, err);
		check_bit("pslverr", err, 1'b1);
		wait_idle();
		check_fill(40, color);
		apb_write(4'h2, 32'h1, err);
		check_bit("pslverr", err, 1'b1);
		apb_read(4'h6, st, err);
		check_bit("pslverr", err, 1'b1);
		apb_write(reg_status, 32'h3, err);
		check_bit("pslverr", err, 1'b1);
	endtask

	initial begin
		repeat (watchdog_cycles) @(posedge clk);
		$display("Watchdog expired before the tests finished");
		$display("TEST FAILED");
		$finish;
	end

	initial begin
		errors = 0;
		rng = 32'hd82b6c95;
		rst     <= 1'b1;
		psel    <= 1'b0;
		penable <= 1'b0;
		pwrite  <= 1'b0;
		paddr   <= '0;
		pwdata  <= '0;
		repeat (2) @(posedge clk);
		rst <= 1'b0;
		reset_state();
		init_sequence();
		random_fill();
		busy_reject();
		$display("Errors: %0d", errors);
		if (errors == 0)
			$display("TEST PASSED");
		else
			$display("TEST FAILED");
		$finish;
	end

endmodule

/* files.f */
hdl/lcd_pkg.sv
hdl/lcd_ifs.sv
hdl/lcd_apb_regs.sv
hdl/lcd_delay_timer.sv
hdl/lcd_init_rom.sv
hdl/lcd_bus_writer.sv
hdl/lcd_sequencer.sv
hdl/lcd_top.sv
dv/lcd_props.sv
dv/lcd_tb.sv

/* Makefile */
TOP = lcd_tb

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing -f files.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert -f files.f --top-module $(TOP) -Mdir obj_dir
	./obj_dir/V$(TOP) | tee sim.log
	grep -q "TEST PASSED" sim.log

clean:
	rm -rf obj_dir sim.log
